/* logic/ftq_pkg.sv */
// fetch target queue shared definitions
// widths, address and id types, queue entry struct
`default_nettype none

package ftq_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int DISP_SIZE = 4;    // slots per dispatch group
  localparam int CMT_ID_W  = 5;
  localparam int VADDR_W   = 32;
  localparam int BIM_IDX_W = 6;    // counter table index bits

  typedef logic [VADDR_W-1:0]   vaddr_t;
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [DISP_SIZE-1:0] grp_id_t;   // one-hot slot
  typedef logic [1:0]           bim_ctr_t;  // 2-bit saturating counter

  // ----------------------------------------------------------
  // queue entry
  // ----------------------------------------------------------
  typedef struct packed {
    logic    valid;
    logic    done;          // resolution received
    logic    notify_valid;  // release produces a frontend update
    logic    dead;
    logic    taken;
    logic    mispredict;
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    vaddr_t  pc_vaddr;
    vaddr_t  target_vaddr;
  } ftq_entry_t;

endpackage

`default_nettype wire

/* logic/br_upd_if.sv */
// branch update bundle
// used for resolutions into the queue and for updates to the frontend
`timescale 1ns/1ps
`default_nettype none

interface br_upd_if;
  import ftq_pkg::*;

  logic    update;       // one-cycle strobe
  logic    taken;
  logic    mispredict;
  logic    dead;
  cmt_id_t cmt_id;
  grp_id_t grp_id;
  vaddr_t  pc_vaddr;
  vaddr_t  target_vaddr;

  modport master (
    output update, taken, mispredict, dead,
    output cmt_id, grp_id, pc_vaddr, target_vaddr
  );

  modport slave (
    input update, taken, mispredict, dead,
    input cmt_id, grp_id, pc_vaddr, target_vaddr
  );

endinterface

`default_nettype wire

/* logic/inoutptr_oh.sv */
// one-hot ring pointers for a circular queue
// write and read pointers, occupancy count, rollback to empty
`timescale 1ns/1ps
`default_nettype none

module inoutptr_oh #(
  parameter int SIZE = 8
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_rollback,
  input  logic                      i_in_valid,
  input  logic                      i_out_valid,
  output logic [SIZE-1:0]           o_in_ptr,
  output logic [SIZE-1:0]           o_out_ptr,
  output logic [$clog2(SIZE+1)-1:0] o_count
);

  logic [SIZE-1:0] w_in_next;
  logic [SIZE-1:0] w_out_next;

  // rotate left by one when the side moves
  assign w_in_next  = i_in_valid  ? {o_in_ptr[SIZE-2:0], o_in_ptr[SIZE-1]} : o_in_ptr;
  assign w_out_next = i_out_valid ? {o_out_ptr[SIZE-2:0], o_out_ptr[SIZE-1]} : o_out_ptr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= {{(SIZE-1){1'b0}}, 1'b1};
      o_out_ptr <= {{(SIZE-1){1'b0}}, 1'b1};
      o_count   <= '0;
    end else begin
      o_out_ptr <= w_out_next;
      if (i_rollback) begin
        o_in_ptr <= w_out_next;  // queue becomes empty at the read side
        o_count  <= '0;
      end else begin
        o_in_ptr <= w_in_next;
        case ({i_in_valid, i_out_valid})
          2'b10:   o_count <= o_count + 1'b1;
          2'b01:   o_count <= o_count - 1'b1;
          default: o_count <= o_count;  // none or both
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* logic/bit_oh_or.sv */
// one-hot select by OR reduction
// payload type is a parameter
`timescale 1ns/1ps
`default_nettype none

module bit_oh_or #(
  parameter type T     = logic,
  parameter int  WORDS = 4
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data[WORDS],
  output T                 o_selected
);

  logic [$bits(T)-1:0] w_acc;

  always_comb begin
    w_acc = '0;
    for (int w_idx = 0; w_idx < WORDS; w_idx++) begin
      if (i_oh[w_idx]) begin
        w_acc = w_acc | i_data[w_idx];  // at most one word set
      end
    end
  end

  assign o_selected = T'(w_acc);

endmodule

`default_nettype wire

/* logic/ftq.sv */
// fetch target queue
// in-order allocation of branch groups, out-of-order resolution,
// in-order release to the frontend, flush on mispredict or commit
`timescale 1ns/1ps
`default_nettype none

module ftq #(
  parameter int FTQ_SIZE = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  ftq_pkg::cmt_id_t i_disp_cmt_id,
  input  ftq_pkg::grp_id_t i_disp_br_mask,
  input  ftq_pkg::vaddr_t  i_disp_pc,
  input  logic             i_commit_flush,
  br_upd_if.slave          res_if,
  br_upd_if.master         fe_if,
  output logic             o_disp_ready,
  output logic             o_ftq_empty
);
  import ftq_pkg::*;

  logic [FTQ_SIZE-1:0]           w_in_ptr;
  logic [FTQ_SIZE-1:0]           w_out_ptr;
  logic [$clog2(FTQ_SIZE+1)-1:0] w_count;
  logic [FTQ_SIZE-1:0]           w_valids;
  logic                          w_in_valid;
  logic                          w_out_valid;
  logic                          w_ftq_flush;

  ftq_entry_t r_entry[FTQ_SIZE];
  ftq_entry_t w_head;
  ftq_entry_t w_new_entry;
  vaddr_t     w_slot_pc[DISP_SIZE];
  vaddr_t     w_br_pc;

  assign o_disp_ready = (w_count < FTQ_SIZE);
  assign o_ftq_empty  = (w_valids == '0);

  assign w_in_valid  = i_disp_valid & o_disp_ready & (|i_disp_br_mask);
  assign w_out_valid = w_head.valid & w_head.done;
  assign w_ftq_flush = i_commit_flush | (fe_if.update & fe_if.mispredict);

  inoutptr_oh #(
    .SIZE (FTQ_SIZE)
  ) u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rollback  (w_ftq_flush),
    .i_in_valid  (w_in_valid),
    .i_out_valid (w_out_valid),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_count     (w_count)
  );

  // ----------------------------------------------------------
  // dispatch side, pick the branch slot address
  // ----------------------------------------------------------
  for (genvar d_idx = 0; d_idx < DISP_SIZE; d_idx++) begin : g_slot_pc
    assign w_slot_pc[d_idx] = i_disp_pc + VADDR_W'(4 * d_idx);
  end

  bit_oh_or #(
    .T     (vaddr_t),
    .WORDS (DISP_SIZE)
  ) u_br_pc_sel (
    .i_oh       (i_disp_br_mask),
    .i_data     (w_slot_pc),
    .o_selected (w_br_pc)
  );

  always_comb begin
    w_new_entry          = '0;
    w_new_entry.valid    = 1'b1;
    w_new_entry.cmt_id   = i_disp_cmt_id;
    w_new_entry.grp_id   = i_disp_br_mask;
    w_new_entry.pc_vaddr = w_br_pc;
  end

  // ----------------------------------------------------------
  // entry array
  // ----------------------------------------------------------
  for (genvar e_idx = 0; e_idx < FTQ_SIZE; e_idx++) begin : g_entry
    logic       w_load;
    logic       w_release;
    logic       w_resolve;
    ftq_entry_t w_entry_next;

    assign w_load    = w_in_valid & w_in_ptr[e_idx];
    assign w_release = w_out_valid & w_out_ptr[e_idx];
    assign w_resolve = res_if.update & r_entry[e_idx].valid &
                       (res_if.cmt_id == r_entry[e_idx].cmt_id) &
                       (res_if.grp_id == r_entry[e_idx].grp_id);
    assign w_valids[e_idx] = r_entry[e_idx].valid;

    always_comb begin
      w_entry_next = r_entry[e_idx];
      if (w_load) begin
        w_entry_next = w_new_entry;
      end
      if (w_release) begin
        w_entry_next.valid = 1'b0;
      end else if (w_ftq_flush) begin
        w_entry_next.valid = 1'b0;  // also drops a same-cycle load
      end else if (w_resolve) begin
        w_entry_next.done         = 1'b1;
        w_entry_next.notify_valid = ~res_if.dead;
        w_entry_next.dead         = res_if.dead;
        w_entry_next.taken        = res_if.taken;
        w_entry_next.mispredict   = res_if.mispredict;
        w_entry_next.target_vaddr = res_if.target_vaddr;
      end
    end

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_entry[e_idx] <= '0;
      end else begin
        r_entry[e_idx] <= w_entry_next;
      end
    end
  end

  // ----------------------------------------------------------
  // head entry to frontend
  // ----------------------------------------------------------
  bit_oh_or #(
    .T     (ftq_entry_t),
    .WORDS (FTQ_SIZE)
  ) u_head_sel (
    .i_oh       (w_out_ptr),
    .i_data     (r_entry),
    .o_selected (w_head)
  );

  assign fe_if.update       = w_head.valid & w_head.done & w_head.notify_valid;
  assign fe_if.taken        = w_head.taken;
  assign fe_if.mispredict   = w_head.mispredict;
  assign fe_if.dead         = w_head.dead;
  assign fe_if.cmt_id       = w_head.cmt_id;
  assign fe_if.grp_id       = w_head.grp_id;
  assign fe_if.pc_vaddr     = w_head.pc_vaddr;
  assign fe_if.target_vaddr = w_head.target_vaddr;

endmodule

`default_nettype wire

/* logic/bim_table.sv */
// bimodal predictor table
// 2-bit saturating counters trained by frontend updates, one read port
`timescale 1ns/1ps
`default_nettype none

module bim_table (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  br_upd_if.slave                         fe_if,
  input  logic [ftq_pkg::BIM_IDX_W-1:0]   i_bim_idx,
  output ftq_pkg::bim_ctr_t               o_bim_ctr
);
  import ftq_pkg::*;

  localparam int BIM_ENTRIES = 1 << BIM_IDX_W;

  bim_ctr_t               r_ctr[BIM_ENTRIES];
  logic [BIM_IDX_W-1:0]   w_upd_idx;
  logic                   w_train;

  assign w_upd_idx = fe_if.pc_vaddr[BIM_IDX_W+1:2];  // word-aligned pc
  assign w_train   = fe_if.update & ~fe_if.dead;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i_idx = 0; i_idx < BIM_ENTRIES; i_idx++) begin
        r_ctr[i_idx] <= 2'd1;  // weakly not taken
      end
    end else if (w_train) begin
      if (fe_if.taken) begin
        if (r_ctr[w_upd_idx] != 2'd3) begin
          r_ctr[w_upd_idx] <= r_ctr[w_upd_idx] + 2'd1;
        end
      end else begin
        if (r_ctr[w_upd_idx] != 2'd0) begin
          r_ctr[w_upd_idx] <= r_ctr[w_upd_idx] - 2'd1;
        end
      end
    end
  end

  assign o_bim_ctr = r_ctr[i_bim_idx];

endmodule

`default_nettype wire

/* logic/ftq_top.sv */
// fetch target queue subsystem top level
// queue plus bimodal table, resolution and update bundles on plain ports
`timescale 1ns/1ps
`default_nettype none

module ftq_top #(
  parameter int FTQ_SIZE = 8
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  // dispatch
  input  logic                          i_disp_valid,
  input  ftq_pkg::cmt_id_t              i_disp_cmt_id,
  input  ftq_pkg::grp_id_t              i_disp_br_mask,
  input  ftq_pkg::vaddr_t               i_disp_pc,
  output logic                          o_disp_ready,
  // resolution
  input  logic                          i_res_update,
  input  ftq_pkg::cmt_id_t              i_res_cmt_id,
  input  ftq_pkg::grp_id_t              i_res_grp_id,
  input  logic                          i_res_taken,
  input  logic                          i_res_mispredict,
  input  logic                          i_res_dead,
  input  ftq_pkg::vaddr_t               i_res_target,
  input  logic                          i_commit_flush,
  output logic                          o_ftq_empty,
  // frontend update
  output logic                          o_upd_valid,
  output logic                          o_upd_taken,
  output logic                          o_upd_mispredict,
  output ftq_pkg::cmt_id_t              o_upd_cmt_id,
  output ftq_pkg::grp_id_t              o_upd_grp_id,
  output ftq_pkg::vaddr_t               o_upd_pc,
  output ftq_pkg::vaddr_t               o_upd_target,
  // counter table read
  input  logic [ftq_pkg::BIM_IDX_W-1:0] i_bim_idx,
  output ftq_pkg::bim_ctr_t             o_bim_ctr
);

  br_upd_if res_if ();
  br_upd_if fe_if ();

  // ----------------------------------------------------------
  // resolution bundle
  // ----------------------------------------------------------
  assign res_if.update       = i_res_update;
  assign res_if.taken        = i_res_taken;
  assign res_if.mispredict   = i_res_mispredict;
  assign res_if.dead         = i_res_dead;
  assign res_if.cmt_id       = i_res_cmt_id;
  assign res_if.grp_id       = i_res_grp_id;
  assign res_if.pc_vaddr     = '0;  // pc comes from the queue entry
  assign res_if.target_vaddr = i_res_target;

  ftq #(
    .FTQ_SIZE (FTQ_SIZE)
  ) u_ftq (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_cmt_id  (i_disp_cmt_id),
    .i_disp_br_mask (i_disp_br_mask),
    .i_disp_pc      (i_disp_pc),
    .i_commit_flush (i_commit_flush),
    .res_if         (res_if.slave),
    .fe_if          (fe_if.master),
    .o_disp_ready   (o_disp_ready),
    .o_ftq_empty    (o_ftq_empty)
  );

  bim_table u_bim (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .fe_if     (fe_if.slave),
    .i_bim_idx (i_bim_idx),
    .o_bim_ctr (o_bim_ctr)
  );

  assign o_upd_valid      = fe_if.update;
  assign o_upd_taken      = fe_if.taken;
  assign o_upd_mispredict = fe_if.mispredict;
  assign o_upd_cmt_id     = fe_if.cmt_id;
  assign o_upd_grp_id     = fe_if.grp_id;
  assign o_upd_pc         = fe_if.pc_vaddr;
  assign o_upd_target     = fe_if.target_vaddr;

endmodule

`default_nettype wire

/* dv/ftq_sva.sv */
// concurrent assertions on the subsystem top
// no update from an empty queue, no allocation while full
// an accepted group makes the queue non-empty
`timescale 1ns/1ps
`default_nettype none

module ftq_sva #(
  parameter int FTQ_SIZE = 8
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_disp_valid,
  input ftq_pkg::grp_id_t    i_disp_br_mask,
  input logic                i_disp_ready,
  input logic                i_commit_flush,
  input logic                i_ftq_empty,
  input logic                i_upd_valid,
  input logic                i_upd_mispredict,
  input logic [FTQ_SIZE-1:0] i_in_ptr       // write pointer of the queue
);

  logic w_flush;
  logic w_offer;

  assign w_flush = i_commit_flush | (i_upd_valid & i_upd_mispredict);
  assign w_offer = i_disp_valid & (i_disp_br_mask != '0);  // group with a branch

  a_no_upd_when_empty : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ftq_empty |-> !i_upd_valid)
    else $error("update strobe while the queue is empty");

  a_in_ptr_held_when_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (!i_disp_ready && !w_flush) |=> $stable(i_in_ptr))
    else $error("write pointer moved while dispatch ready is low");

  a_accept_fills_queue : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_offer && i_disp_ready && !w_flush) |=> !i_ftq_empty)
    else $error("accepted group did not reach the queue");

endmodule

`default_nettype wire

/* dv/ftq_checker.sv */
// reference model of the queue and the counter table
// compares release updates, ready, empty and counter reads
`timescale 1ns/1ps
`default_nettype none

module ftq_checker #(
  parameter int FTQ_SIZE = 8
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_disp_valid,
  input  ftq_pkg::cmt_id_t              i_disp_cmt_id,
  input  ftq_pkg::grp_id_t              i_disp_br_mask,
  input  ftq_pkg::vaddr_t               i_disp_pc,
  input  logic                          i_res_update,
  input  ftq_pkg::cmt_id_t              i_res_cmt_id,
  input  ftq_pkg::grp_id_t              i_res_grp_id,
  input  logic                          i_res_taken,
  input  logic                          i_res_mispredict,
  input  logic                          i_res_dead,
  input  ftq_pkg::vaddr_t               i_res_target,
  input  logic                          i_commit_flush,
  input  logic [ftq_pkg::BIM_IDX_W-1:0] i_bim_idx,
  input  logic                          i_disp_ready,
  input  logic                          i_ftq_empty,
  input  logic                          i_upd_valid,
  input  logic                          i_upd_taken,
  input  logic                          i_upd_mispredict,
  input  ftq_pkg::cmt_id_t              i_upd_cmt_id,
  input  ftq_pkg::grp_id_t              i_upd_grp_id,
  input  ftq_pkg::vaddr_t               i_upd_pc,
  input  ftq_pkg::vaddr_t               i_upd_target,
  input  ftq_pkg::bim_ctr_t             i_bim_ctr,
  output int                            o_err_count,
  output int                            o_upd_count
);
  import ftq_pkg::*;

  typedef struct packed {
    cmt_id_t cmt_id;
    grp_id_t grp_id;
    vaddr_t  pc;
    vaddr_t  target;
    logic    done;
    logic    dead;
    logic    taken;
    logic    mispredict;
  } model_entry_t;

  model_entry_t         q[$];           // oldest entry at the front
  bim_ctr_t             ctr[1 << BIM_IDX_W];
  model_entry_t         head;
  model_entry_t         new_ent;
  logic                 exp_upd;
  logic                 do_release;
  logic                 do_flush;
  logic                 do_accept;
  logic                 found;
  logic [BIM_IDX_W-1:0] trn_idx;
  int                   slot;
  int                   err_cnt = 0;
  int                   upd_cnt = 0;

  assign o_err_count = err_cnt;
  assign o_upd_count = upd_cnt;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s dut=%0h model=%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      q.delete();
      for (int c_idx = 0; c_idx < (1 << BIM_IDX_W); c_idx++) begin
        ctr[c_idx] = 2'd1;  // weakly not taken
      end
    end else begin
      // ------------------------------------------------------
      // compare outputs seen before this edge
      // ------------------------------------------------------
      head    = (q.size() > 0) ? q[0] : '0;
      exp_upd = (q.size() > 0) && head.done && !head.dead;
      check_val("o_upd_valid", 32'(i_upd_valid), 32'(exp_upd));
      check_val("o_disp_ready", 32'(i_disp_ready), 32'(q.size() < FTQ_SIZE));
      check_val("o_ftq_empty", 32'(i_ftq_empty), 32'(q.size() == 0));
      check_val("o_bim_ctr", 32'(i_bim_ctr), 32'(ctr[i_bim_idx]));
      if (exp_upd && i_upd_valid) begin
        check_val("o_upd_cmt_id", 32'(i_upd_cmt_id), 32'(head.cmt_id));
        check_val("o_upd_grp_id", 32'(i_upd_grp_id), 32'(head.grp_id));
        check_val("o_upd_pc", i_upd_pc, head.pc);
        check_val("o_upd_taken", 32'(i_upd_taken), 32'(head.taken));
        check_val("o_upd_mispredict", 32'(i_upd_mispredict), 32'(head.mispredict));
        check_val("o_upd_target", i_upd_target, head.target);
        upd_cnt++;
      end
      if (exp_upd) begin
        trn_idx = head.pc[BIM_IDX_W+1:2];
        if (head.taken && (ctr[trn_idx] != 2'd3)) begin
          ctr[trn_idx] = ctr[trn_idx] + 2'd1;
        end else if (!head.taken && (ctr[trn_idx] != 2'd0)) begin
          ctr[trn_idx] = ctr[trn_idx] - 2'd1;
        end
      end

      // ------------------------------------------------------
      // advance the model queue
      // ------------------------------------------------------
      do_release = (q.size() > 0) && head.done;
      do_flush   = i_commit_flush || (exp_upd && head.mispredict);
      do_accept  = i_disp_valid && (q.size() < FTQ_SIZE) && (i_disp_br_mask != '0);
      if (do_release) begin
        void'(q.pop_front());
      end
      if (do_flush) begin
        q.delete();  // a same-edge group is lost too
      end else begin
        found = 1'b0;
        for (int e_idx = 0; e_idx < q.size(); e_idx++) begin
          if (i_res_update && !found && (q[e_idx].cmt_id == i_res_cmt_id) &&
              (q[e_idx].grp_id == i_res_grp_id)) begin
            q[e_idx].done       = 1'b1;
            q[e_idx].dead       = i_res_dead;
            q[e_idx].taken      = i_res_taken;
            q[e_idx].mispredict = i_res_mispredict;
            q[e_idx].target     = i_res_target;
            found = 1'b1;
          end
        end
        if (do_accept) begin
          slot = 0;
          for (int s_idx = 0; s_idx < DISP_SIZE; s_idx++) begin
            if (i_disp_br_mask[s_idx]) begin
              slot = s_idx;
            end
          end
          new_ent        = '0;
          new_ent.cmt_id = i_disp_cmt_id;
          new_ent.grp_id = i_disp_br_mask;
          new_ent.pc     = i_disp_pc + vaddr_t'(4 * slot);  // base plus slot offset
          q.push_back(new_ent);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_ftq.sv */
// testbench for the fetch target queue subsystem
// clock, reset, seeded random dispatch, resolution and flush, summary
`timescale 1ns/1ps
`default_nettype none

module tb_ftq;
  import ftq_pkg::*;

  localparam int FTQ_SIZE      = 8;
  localparam int RUN_CYCLES    = 4000;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int SEED          = 25425;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_disp_valid;
  cmt_id_t              i_disp_cmt_id;
  grp_id_t              i_disp_br_mask;
  vaddr_t               i_disp_pc;
  logic                 i_res_update;
  cmt_id_t              i_res_cmt_id;
  grp_id_t              i_res_grp_id;
  logic                 i_res_taken;
  logic                 i_res_mispredict;
  logic                 i_res_dead;
  vaddr_t               i_res_target;
  logic                 i_commit_flush;
  logic [BIM_IDX_W-1:0] i_bim_idx;
  logic                 o_disp_ready;
  logic                 o_ftq_empty;
  logic                 o_upd_valid;
  logic                 o_upd_taken;
  logic                 o_upd_mispredict;
  cmt_id_t              o_upd_cmt_id;
  grp_id_t              o_upd_grp_id;
  vaddr_t               o_upd_pc;
  vaddr_t               o_upd_target;
  bim_ctr_t             o_bim_ctr;

  int      err_count;
  int      upd_count;
  cmt_id_t pend_cmt[$];   // dispatched and not yet resolved
  grp_id_t pend_grp[$];
  cmt_id_t next_cmt;
  logic    flush_seen;
  logic    accepted;
  logic    drained;

  ftq_top #(
    .FTQ_SIZE (FTQ_SIZE)
  ) dut_i (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_cmt_id    (i_disp_cmt_id),
    .i_disp_br_mask   (i_disp_br_mask),
    .i_disp_pc        (i_disp_pc),
    .o_disp_ready     (o_disp_ready),
    .i_res_update     (i_res_update),
    .i_res_cmt_id     (i_res_cmt_id),
    .i_res_grp_id     (i_res_grp_id),
    .i_res_taken      (i_res_taken),
    .i_res_mispredict (i_res_mispredict),
    .i_res_dead       (i_res_dead),
    .i_res_target     (i_res_target),
    .i_commit_flush   (i_commit_flush),
    .o_ftq_empty      (o_ftq_empty),
    .o_upd_valid      (o_upd_valid),
    .o_upd_taken      (o_upd_taken),
    .o_upd_mispredict (o_upd_mispredict),
    .o_upd_cmt_id     (o_upd_cmt_id),
    .o_upd_grp_id     (o_upd_grp_id),
    .o_upd_pc         (o_upd_pc),
    .o_upd_target     (o_upd_target),
    .i_bim_idx        (i_bim_idx),
    .o_bim_ctr        (o_bim_ctr)
  );

  ftq_checker #(
    .FTQ_SIZE (FTQ_SIZE)
  ) chk_i (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_cmt_id    (i_disp_cmt_id),
    .i_disp_br_mask   (i_disp_br_mask),
    .i_disp_pc        (i_disp_pc),
    .i_res_update     (i_res_update),
    .i_res_cmt_id     (i_res_cmt_id),
    .i_res_grp_id     (i_res_grp_id),
    .i_res_taken      (i_res_taken),
    .i_res_mispredict (i_res_mispredict),
    .i_res_dead       (i_res_dead),
    .i_res_target     (i_res_target),
    .i_commit_flush   (i_commit_flush),
    .i_bim_idx        (i_bim_idx),
    .i_disp_ready     (o_disp_ready),
    .i_ftq_empty      (o_ftq_empty),
    .i_upd_valid      (o_upd_valid),
    .i_upd_taken      (o_upd_taken),
    .i_upd_mispredict (o_upd_mispredict),
    .i_upd_cmt_id     (o_upd_cmt_id),
    .i_upd_grp_id     (o_upd_grp_id),
    .i_upd_pc         (o_upd_pc),
    .i_upd_target     (o_upd_target),
    .i_bim_ctr        (o_bim_ctr),
    .o_err_count      (err_count),
    .o_upd_count      (upd_count)
  );

  bind ftq_top ftq_sva #(
    .FTQ_SIZE (FTQ_SIZE)
  ) sva_i (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_br_mask   (i_disp_br_mask),
    .i_disp_ready     (o_disp_ready),
    .i_commit_flush   (i_commit_flush),
    .i_ftq_empty      (o_ftq_empty),
    .i_upd_valid      (o_upd_valid),
    .i_upd_mispredict (o_upd_mispredict),
    .i_in_ptr         (u_ftq.w_in_ptr)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------
  // per-edge stimulus helpers
  // ----------------------------------------------------------
  task automatic track_edge();
    flush_seen = i_commit_flush | (o_upd_valid & o_upd_mispredict);
    accepted   = i_disp_valid & o_disp_ready & (|i_disp_br_mask);
    if (flush_seen) begin
      pend_cmt.delete();  // everything outstanding is gone
      pend_grp.delete();
    end else if (accepted) begin
      pend_cmt.push_back(i_disp_cmt_id);
      pend_grp.push_back(i_disp_br_mask);
    end
    if (o_upd_valid) begin
      i_bim_idx <= o_upd_pc[BIM_IDX_W+1:2];  // read back the trained counter
    end
  endtask

  task automatic drive_dispatch(input logic allow_new);
    int   slot;
    logic hold;
    slot = int'($urandom_range(0, DISP_SIZE - 1));
    hold = i_disp_valid & ~accepted & ~flush_seen & (|i_disp_br_mask);
    if (!hold) begin
      if (allow_new && ($urandom_range(0, 99) < 60)) begin
        i_disp_valid   <= 1'b1;
        i_disp_cmt_id  <= next_cmt;
        i_disp_br_mask <= ($urandom_range(0, 7) == 0) ? '0 : grp_id_t'(1 << slot);
        i_disp_pc      <= $urandom & 32'hffff_f03c;  // few table indexes
        next_cmt = next_cmt + 1'b1;
      end else begin
        i_disp_valid <= 1'b0;
      end
    end
  endtask

  task automatic drive_resolution(input int pct);
    int pick;
    if ((pend_cmt.size() > 0) && ($urandom_range(0, 99) < pct)) begin
      pick = int'($urandom_range(0, pend_cmt.size() - 1));
      i_res_update     <= 1'b1;
      i_res_cmt_id     <= pend_cmt[pick];
      i_res_grp_id     <= pend_grp[pick];
      i_res_taken      <= 1'($urandom_range(0, 1));
      i_res_mispredict <= ($urandom_range(0, 19) == 0);
      i_res_dead       <= ($urandom_range(0, 7) == 0);
      i_res_target     <= $urandom;
      pend_cmt.delete(pick);
      pend_grp.delete(pick);
    end else begin
      i_res_update <= 1'b0;
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    i_reset_n        = 1'b0;
    i_disp_valid     = 1'b0;
    i_disp_cmt_id    = '0;
    i_disp_br_mask   = '0;
    i_disp_pc        = '0;
    i_res_update     = 1'b0;
    i_res_cmt_id     = '0;
    i_res_grp_id     = '0;
    i_res_taken      = 1'b0;
    i_res_mispredict = 1'b0;
    i_res_dead       = 1'b0;
    i_res_target     = '0;
    i_commit_flush   = 1'b0;
    i_bim_idx        = '0;
    next_cmt         = '0;
    flush_seen       = 1'b0;
    accepted         = 1'b0;
    drained          = 1'b0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;

    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(posedge i_clk);
      track_edge();
      drive_dispatch(1'b1);
      drive_resolution(40);
      i_commit_flush <= ($urandom_range(0, 199) == 0);  // rare
    end

    // resolve everything left and let the queue empty
    for (int cyc = 0; (cyc < DRAIN_TIMEOUT) && !drained; cyc++) begin
      @(posedge i_clk);
      track_edge();
      if (o_ftq_empty && !i_disp_valid && !i_commit_flush && (pend_cmt.size() == 0)) begin
        drained = 1'b1;
      end
      drive_dispatch(1'b0);
      drive_resolution(100);
      i_commit_flush <= 1'b0;
    end

    if (!drained) begin
      $display("timeout: queue did not drain within %0d cycles", DRAIN_TIMEOUT);
    end
    $display("summary: errors=%0d updates=%0d drained=%0d", err_count, upd_count, drained);
    if (drained && (err_count == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/ftq_pkg.sv
logic/br_upd_if.sv
logic/inoutptr_oh.sv
logic/bit_oh_or.sv
logic/ftq.sv
logic/bim_table.sv
logic/ftq_top.sv
dv/ftq_sva.sv
dv/ftq_checker.sv
dv/tb_ftq.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_ftq -o tb_ftq_sim \
  && ./obj_dir/tb_ftq_sim | tee sim.log \
  && grep -q '^\*\* PASS \*\*$' sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation did not pass"; exit 1; }
